//--- Makefile
# Verilator build and run of the multiply/divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= risu64_muldiv.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) -o V$(TOP)

# the run passes only if the pass message shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/div.sv
// ################################################
// iterative radix-2 restoring divider for the M extension
// handles divide by zero and signed overflow in one step,
// otherwise one quotient bit per cycle plus a sign fix cycle
// same request/response handshake as the multiplier
// ################################################

module div import risu64_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  md_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,
    output md_resp_t resp,
    output logic     resp_valid
);

    localparam int WORD_STEPS = DIV_STEPS / 2;
    localparam int CNT_W = $clog2(DIV_STEPS + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREP,
        ST_ITER,
        ST_FIX
    } state_e;

    state_e state;
    logic accept;
    logic [CNT_W-1:0] cnt;

    // decode of the incoming op and its registered copy
    logic dec_signed;
    logic dec_rem;
    logic dec_word;
    logic op_signed;
    logic op_rem;
    logic op_word;

    // operands after word-mode extension, kept for the sign fix
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;

    // restoring datapath
    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] part_rem;
    logic [XLEN-1:0] dvs;
    logic [XLEN:0]   shifted;
    logic [XLEN+1:0] trial;
    logic [XLEN-1:0] mag_a;
    logic [XLEN-1:0] mag_b;

    // special cases and result forming
    logic div_zero;
    logic overflow;
    logic special;
    logic [XLEN-1:0] special_res;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;
    logic [XLEN-1:0] fix_res;

    // low word of v, extended with its sign when sgn is set
    function automatic logic [XLEN-1:0] ext_word(input logic [XLEN-1:0] v, input logic sgn);
        ext_word = {{(XLEN - 32){sgn & v[31]}}, v[31:0]};
    endfunction

    assign req_ready = (state == ST_IDLE);
    assign accept = req_valid && req_ready;

    // the op encoding carries the three properties directly
    always_comb begin
        dec_signed = (req.op.div == DO_DIV) || (req.op.div == DO_REM) ||
                     (req.op.div == DO_DIVW) || (req.op.div == DO_REMW);
        dec_rem = (req.op.div == DO_REM) || (req.op.div == DO_REMU) ||
                  (req.op.div == DO_REMW) || (req.op.div == DO_REMUW);
        dec_word = (req.op.div == DO_DIVW) || (req.op.div == DO_DIVUW) ||
                   (req.op.div == DO_REMW) || (req.op.div == DO_REMUW);
    end

    // word operands are already extended, so a 64-bit compare covers both widths
    always_comb begin
        div_zero = (b_q == '0);
        if (op_word) begin
            overflow = op_signed && (b_q == '1) && (a_q == {{(XLEN - 31){1'b1}}, 31'd0});
        end else begin
            overflow = op_signed && (b_q == '1) && (a_q == {1'b1, {(XLEN - 1){1'b0}}});
        end
        special = div_zero || overflow;
        // RISC-V defined results, quotient all ones on zero divisor
        if (div_zero) begin
            special_res = op_rem ? a_q : '1;
        end else begin
            special_res = op_rem ? '0 : a_q;
        end
        mag_a = (op_signed && a_q[XLEN-1]) ? -a_q : a_q;
        mag_b = (op_signed && b_q[XLEN-1]) ? -b_q : b_q;
    end

    // one restoring step, the spare top bit of trial is the borrow
    assign shifted = {part_rem, quo[XLEN-1]};
    assign trial = {1'b0, shifted} - {2'b00, dvs};

    // quotient is negative when the signs differ, remainder follows the dividend
    always_comb begin
        quo_fix = (op_signed && (a_q[XLEN-1] ^ b_q[XLEN-1])) ? -quo : quo;
        rem_fix = (op_signed && a_q[XLEN-1]) ? -part_rem : part_rem;
        fix_res = op_rem ? rem_fix : quo_fix;
    end

    // control FSM and step counter
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            resp_valid <= 1'b0;
            cnt <= '0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_PREP;
                    end
                end
                ST_PREP: begin
                    if (special) begin
                        state <= ST_IDLE;
                        resp_valid <= 1'b1;
                    end else begin
                        state <= ST_ITER;
                        cnt <= op_word ? CNT_W'(WORD_STEPS) : CNT_W'(DIV_STEPS);
                    end
                end
                ST_ITER: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == CNT_W'(1)) begin
                        state <= ST_FIX;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    resp_valid <= 1'b1;
                end
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    op_signed <= dec_signed;
                    op_rem <= dec_rem;
                    op_word <= dec_word;
                    a_q <= dec_word ? ext_word(req.operand1, dec_signed) : req.operand1;
                    b_q <= dec_word ? ext_word(req.operand2, dec_signed) : req.operand2;
                end
            end
            ST_PREP: begin
                // a word dividend starts at the top so 32 steps consume it
                quo <= op_word ? {mag_a[31:0], 32'd0} : mag_a;
                part_rem <= '0;
                dvs <= mag_b;
                resp.result <= op_word ? ext_word(special_res, 1'b1) : special_res;
            end
            ST_ITER: begin
                if (!trial[XLEN+1]) begin
                    part_rem <= trial[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b1};
                end else begin
                    part_rem <= shifted[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b0};
                end
            end
            default: begin
                resp.result <= op_word ? ext_word(fix_res, 1'b1) : fix_res;
            end
        endcase
    end

endmodule

//--- design/mul.sv
// ################################################
// iterative 64-bit multiplier for the M extension
// one 33x33 signed multiply-accumulate per cycle over the
// LL, HL, LH and HH partial products, taking 1 to 4 steps
// accepts on req_valid && req_ready, answers with a resp_valid pulse
// ################################################

module mul import risu64_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  md_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,
    output md_resp_t resp,
    output logic     resp_valid
);

    // the state order is free, the mac selects are decoded from the name
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LL,
        ST_HL,
        ST_LH,
        ST_HH
    } state_e;

    state_e state;
    logic accept;

    // operands widened to 65 bits so that every multiply is signed
    logic [64:0] opa;
    logic [64:0] opb;
    logic a_signed;
    logic b_signed;

    // what the accepted operation needs from the datapath
    logic op_word;
    logic op_low;
    logic op_high;

    // multiply-accumulate datapath
    logic signed [32:0] mac_a;
    logic signed [32:0] mac_b;
    logic signed [65:0] acc;
    logic signed [65:0] prod;

    assign req_ready = (state == ST_IDLE);
    assign accept = req_valid && req_ready;

    // MULHU treats both operands as unsigned, MULHSU only the second one
    always_comb begin
        a_signed = (req.op.mul != MO_MULHU);
        b_signed = (req.op.mul != MO_MULHU) && (req.op.mul != MO_MULHSU);
    end

    // the upper half of a 65-bit operand is a 33-bit signed number,
    // the lower half is unsigned and gets a zero on top
    always_comb begin
        if ((state == ST_HL) || (state == ST_HH)) begin
            mac_a = $signed(opa[64:32]);
        end else begin
            mac_a = $signed({1'b0, opa[31:0]});
        end
        if ((state == ST_LH) || (state == ST_HH)) begin
            mac_b = $signed(opb[64:32]);
        end else begin
            mac_b = $signed({1'b0, opb[31:0]});
        end
    end

    // a 66-bit accumulator is wide enough for every intermediate sum
    assign prod = acc + 66'(mac_a) * 66'(mac_b);

    // control FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_LL;
                    end
                end
                ST_LL: begin
                    // the low product alone gives the whole answer here
                    if (op_word || op_low) begin
                        state <= ST_IDLE;
                        resp_valid <= 1'b1;
                    end else begin
                        state <= ST_HL;
                    end
                end
                ST_HL: begin
                    state <= ST_LH;
                end
                ST_LH: begin
                    if (op_high) begin
                        state <= ST_HH;
                    end else begin
                        state <= ST_IDLE;
                        resp_valid <= 1'b1;
                    end
                end
                ST_HH: begin
                    state <= ST_IDLE;
                    resp_valid <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    opa <= {a_signed & req.operand1[XLEN-1], req.operand1};
                    opb <= {b_signed & req.operand2[XLEN-1], req.operand2};
                    op_word <= (req.op.mul == MO_MULW);
                    op_high <= (req.op.mul == MO_MULH) || (req.op.mul == MO_MULHSU) ||
                               (req.op.mul == MO_MULHU);
                    // both upper words zero means the low product is complete
                    op_low <= (req.op.mul == MO_MUL) &&
                              (req.operand1[63:32] == 32'd0) &&
                              (req.operand2[63:32] == 32'd0);
                    acc <= '0;
                end
            end
            ST_LL: begin
                resp.result[31:0] <= prod[31:0];
                if (op_word) begin
                    resp.result[63:32] <= {32{prod[31]}};
                end else begin
                    resp.result[63:32] <= prod[63:32];
                end
                // move on to the weight 2^32 column
                acc <= {{32{prod[65]}}, prod[65:32]};
            end
            ST_HL: begin
                // HL and LH share a weight so no shift in between
                acc <= prod;
            end
            ST_LH: begin
                resp.result[63:32] <= prod[31:0];
                acc <= {{32{prod[65]}}, prod[65:32]};
            end
            ST_HH: begin
                // accumulator now sits at weight 2^64, the high half of the product
                resp.result <= prod[63:0];
            end
            default: begin
                acc <= '0;
            end
        endcase
    end

endmodule

//--- design/muldiv_unit.sv
// ################################################
// multiply/divide unit of the execute stage
// sends each request to the multiplier or the divider,
// keeps a single operation in flight and merges the responses
// ################################################

module muldiv_unit import risu64_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  md_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,
    output md_resp_t resp,
    output logic     resp_valid
);

    // per-unit handshake signals
    logic     mul_req_valid;
    logic     mul_req_ready;
    md_resp_t mul_resp;
    logic     mul_resp_valid;
    logic     div_req_valid;
    logic     div_req_ready;
    md_resp_t div_resp;
    logic     div_resp_valid;

    // new work only goes in when both units are idle, which keeps
    // responses in request order
    assign req_ready = mul_req_ready && div_req_ready;

    // a unit that is idle must not see valid while the other one is busy,
    // otherwise it would accept behind the top-level handshake
    assign mul_req_valid = req_valid && req_ready && !req.is_div;
    assign div_req_valid = req_valid && req_ready && req.is_div;

    mul u_mul (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (mul_req_valid),
        .req_ready  (mul_req_ready),
        .resp       (mul_resp),
        .resp_valid (mul_resp_valid)
    );

    div u_div (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (div_req_valid),
        .req_ready  (div_req_ready),
        .resp       (div_resp),
        .resp_valid (div_resp_valid)
    );

    // at most one unit answers in a cycle since only one is ever busy
    always_comb begin
        resp_valid = mul_resp_valid || div_resp_valid;
        if (div_resp_valid) begin
            resp = div_resp;
        end else begin
            resp = mul_resp;
        end
    end

endmodule

//--- design/risu64_pkg.sv
// ################################################
// shared definitions of the multiply/divide unit
// holds the operation encodings, the op union and the
// request/response structs used by the RTL and the testbench
// import with risu64_pkg::* in the module header
// ################################################

package risu64_pkg;

    // data width of the core
    localparam int XLEN = 64;

    // quotient bits produced by a full-width division
    // word forms run half of these inside the divider
    localparam int DIV_STEPS = 64;

    // multiply operations, as seen through the mul view of the op field
    typedef enum logic [2:0] {
        MO_MUL    = 3'd0,
        MO_MULH   = 3'd1,
        MO_MULHSU = 3'd2,
        MO_MULHU  = 3'd3,
        MO_MULW   = 3'd4
    } mul_op_e;

    // divide operations, as seen through the div view of the op field
    // bit 0 marks unsigned, bit 1 marks remainder, bit 2 marks word mode
    typedef enum logic [2:0] {
        DO_DIV   = 3'd0,
        DO_DIVU  = 3'd1,
        DO_REM   = 3'd2,
        DO_REMU  = 3'd3,
        DO_DIVW  = 3'd4,
        DO_DIVUW = 3'd5,
        DO_REMW  = 3'd6,
        DO_REMUW = 3'd7
    } div_op_e;

    // the same three bits read as either kind of operation
    // is_div in the request picks the view that is valid
    typedef union packed {
        mul_op_e mul;
        div_op_e div;
    } md_op_u;

    // one request to the unit, 132 bits
    typedef struct packed {
        logic              is_div;
        md_op_u            op;
        logic [XLEN-1:0]   operand1;
        logic [XLEN-1:0]   operand2;
    } md_req_t;

    // one response, valid only while resp_valid is high
    typedef struct packed {
        logic [XLEN-1:0]   result;
    } md_resp_t;

endpackage

//--- dv/muldiv_asserts.sv
// ################################################
// concurrent checks on the top-level handshake of the
// multiply/divide unit, attached to muldiv_unit by bind
// the testbench adds fail_count to its error total
// ################################################

module muldiv_asserts import risu64_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     req_valid,
    input logic     req_ready,
    input md_resp_t resp,
    input logic     resp_valid
);

    // number of assertion failures seen so far
    int fail_count = 0;

    // set by an accepted request, cleared by its response
    logic busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
        end else if (resp_valid) begin
            busy <= 1'b0;
        end
    end

    // a response is a single-cycle pulse
    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid)
        else begin
            $error("resp_valid was high on two consecutive cycles");
            fail_count++;
        end

    // nothing new is taken while an operation is in flight
    a_ready_held: assert property (@(posedge clk) disable iff (rst)
        (busy && !resp_valid) |-> !req_ready)
        else begin
            $error("req_ready rose before the response of the accepted request");
            fail_count++;
        end

    a_resp_known: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !$isunknown(resp))
        else begin
            $error("resp has unknown bits while resp_valid is high");
            fail_count++;
        end

    // reset leaves both units idle with no response pending
    a_idle_after_reset: assert property (@(posedge clk) rst |=> !resp_valid)
        else begin
            $error("resp_valid was high on the cycle after reset");
            fail_count++;
        end

endmodule

bind muldiv_unit muldiv_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid)
);

//--- dv/tb_top.sv
// ################################################
// directed testbench for the multiply/divide unit
// drives requests on the falling edge, waits for resp_valid
// and compares each result with a 128-bit reference model
// ################################################

module tb_top import risu64_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int SEED = 68912;
    localparam int N_RAND = 20;
    localparam int RESP_LIMIT = 100;
    // results, latency, divide results, special cases and mixed traffic
    localparam int TOTAL_OPS = 5 * (25 + N_RAND) + 7 + 8 * (25 + N_RAND) + 12 + 8;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 80 + RESET_CYCLES + 200;

    logic clk;
    logic rst;
    md_req_t req;
    logic req_valid;
    logic req_ready;
    md_resp_t resp;
    logic resp_valid;

    int n_checks;
    int n_errors;
    int n_tests;

    // zero, one, all ones, most negative and most positive
    logic [63:0] corners [5] = '{64'd0, 64'd1, '1, 64'h8000_0000_0000_0000,
                                 64'h7fff_ffff_ffff_ffff};

    muldiv_unit dut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // a 64-bit divide is the longest operation and needs well under 80 cycles
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string msg);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        n_tests++;
        if (n_errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, n_errors - errors_before);
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // the op code is read through the view that is_div selects
    function automatic md_req_t make_req(input logic is_div, input logic [2:0] code,
                                         input logic [63:0] a, input logic [63:0] b);
        md_req_t r;
        r.is_div = is_div;
        if (is_div) begin
            r.op.div = div_op_e'(code);
        end else begin
            r.op.mul = mul_op_e'(code);
        end
        r.operand1 = a;
        r.operand2 = b;
        return r;
    endfunction

    // the 128-bit product of the extended operands is exact for every signedness mix
    function automatic logic [63:0] model_mul(input mul_op_e op, input logic [63:0] a,
                                              input logic [63:0] b);
        logic [127:0] xa;
        logic [127:0] xb;
        logic [127:0] p;
        xa = (op == MO_MULHU) ? {64'd0, a} : {{64{a[63]}}, a};
        xb = (op == MO_MULHU || op == MO_MULHSU) ? {64'd0, b} : {{64{b[63]}}, b};
        p = xa * xb;
        case (op)
            MO_MUL: return p[63:0];
            MO_MULW: return {{32{p[31]}}, p[31:0]};
            default: return p[127:64];
        endcase
    endfunction

    // signed overflow needs no special case here because the wide quotient
    // wraps to the dividend when cut back to the operation width
    function automatic logic [63:0] model_div(input div_op_e op, input logic [63:0] a,
                                              input logic [63:0] b);
        logic is_signed;
        logic is_rem;
        logic is_word;
        logic signed [127:0] xa;
        logic signed [127:0] xb;
        logic [127:0] r;
        is_signed = op inside {DO_DIV, DO_REM, DO_DIVW, DO_REMW};
        is_rem = op inside {DO_REM, DO_REMU, DO_REMW, DO_REMUW};
        is_word = op inside {DO_DIVW, DO_DIVUW, DO_REMW, DO_REMUW};
        if (is_word) begin
            xa = is_signed ? {{96{a[31]}}, a[31:0]} : {96'd0, a[31:0]};
            xb = is_signed ? {{96{b[31]}}, b[31:0]} : {96'd0, b[31:0]};
        end else begin
            xa = is_signed ? {{64{a[63]}}, a} : {64'd0, a};
            xb = is_signed ? {{64{b[63]}}, b} : {64'd0, b};
        end
        // a zero divisor gives an all-ones quotient and the dividend as remainder
        if (xb == 0) begin
            r = is_rem ? xa : '1;
        end else begin
            r = is_rem ? xa % xb : xa / xb;
        end
        if (is_word) begin
            return {{32{r[31]}}, r[31:0]};
        end
        return r[63:0];
    endfunction

    // sends one request and waits for its response, counting cycles from the accept edge
    task automatic issue(input md_req_t r, output logic [63:0] result, output int cycles);
        int waited;
        logic held;
        waited = 0;
        held = 1'b1;
        cycles = 0;
        result = '0;
        while (!req_ready && waited < RESP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            $display("error at %0t: req_ready stayed low, the request was not sent", $time);
            n_errors++;
            return;
        end
        req = r;
        req_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        while (!resp_valid && cycles < RESP_LIMIT) begin
            held = held && !req_ready;
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        if (!resp_valid) begin
            $display("error at %0t: no response within %0d cycles", $time, RESP_LIMIT);
            n_errors++;
            return;
        end
        result = resp.result;
        check_eq(64'(held), 64'd1, "req_ready low while the operation is in flight");
    endtask

    task automatic run_timed(input md_req_t r, input logic [63:0] expected, input int lat,
                             input string name);
        logic [63:0] got;
        int cyc;
        issue(r, got, cyc);
        check_eq(got, expected, name);
        check_eq(64'(cyc), 64'(lat), {name, " latency"});
    endtask

    task automatic pick_operands(input int n, output logic [63:0] a, output logic [63:0] b);
        if (n < 25) begin
            a = corners[n / 5];
            b = corners[n % 5];
        end else begin
            a = rand64();
            // shifting the divisor gives quotients of every size
            b = rand64() >> ($urandom % 64);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = n_errors;
        check_eq(64'(req_ready), 64'd1, "req_ready after reset");
        check_eq(64'(resp_valid), 64'd0, "resp_valid after reset");
        report_test("reset state", e0);
    endtask

    // every op of one unit over all corner pairs and N_RAND random pairs
    task automatic test_results(input logic is_div);
        int e0;
        int cyc;
        int n_ops;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] got;
        logic [63:0] want;
        e0 = n_errors;
        n_ops = is_div ? 8 : 5;
        for (int k = 0; k < n_ops; k++) begin
            for (int n = 0; n < 25 + N_RAND; n++) begin
                pick_operands(n, a, b);
                issue(make_req(is_div, 3'(k), a, b), got, cyc);
                want = is_div ? model_div(div_op_e'(k), a, b) : model_mul(mul_op_e'(k), a, b);
                check_eq(got, want, $sformatf("op %0d a=%h b=%h", k, a, b));
            end
        end
        report_test(is_div ? "divide results" : "multiply results", e0);
    endtask

    task automatic test_mul_latency();
        int e0;
        logic [63:0] a;
        logic [63:0] b;
        e0 = n_errors;
        a = 64'hffff_0000_1234_5678;
        b = 64'h8000_0000_ffff_ffff;
        run_timed(make_req(1'b0, MO_MULW, a, b), model_mul(MO_MULW, a, b), 1, "MULW");
        run_timed(make_req(1'b0, MO_MUL, 64'hffff_ffff, 64'h8765_4321),
                  64'h8765_4320_789a_bcdf, 1, "MUL low operands");
        run_timed(make_req(1'b0, MO_MUL, 64'h1_0000_0000, 64'd3), 64'h3_0000_0000, 3,
                  "MUL wide operand");
        run_timed(make_req(1'b0, MO_MUL, a, b), model_mul(MO_MUL, a, b), 3, "MUL");
        run_timed(make_req(1'b0, MO_MULH, a, b), model_mul(MO_MULH, a, b), 4, "MULH");
        run_timed(make_req(1'b0, MO_MULHSU, a, b), model_mul(MO_MULHSU, a, b), 4, "MULHSU");
        run_timed(make_req(1'b0, MO_MULHU, a, b), model_mul(MO_MULHU, a, b), 4, "MULHU");
        report_test("multiply latency", e0);
    endtask

    // expected values written out from the RISC-V rules
    task automatic test_div_special();
        int e0;
        logic [63:0] a;
        logic [63:0] wz;
        logic [63:0] wmin;
        logic [63:0] wm1;
        e0 = n_errors;
        a = 64'h8123_4567_89ab_cdef;
        // word operands only use their low halves
        wz = 64'hdead_0000_0000_0000;
        wmin = 64'h1234_5678_8000_0000;
        wm1 = 64'h0000_0000_ffff_ffff;
        run_timed(make_req(1'b1, DO_DIV, a, 64'd0), '1, 1, "DIV by zero");
        run_timed(make_req(1'b1, DO_DIVU, a, 64'd0), '1, 1, "DIVU by zero");
        run_timed(make_req(1'b1, DO_REM, a, 64'd0), a, 1, "REM by zero");
        run_timed(make_req(1'b1, DO_REMU, a, 64'd0), a, 1, "REMU by zero");
        run_timed(make_req(1'b1, DO_DIV, corners[3], '1), corners[3], 1, "DIV overflow");
        run_timed(make_req(1'b1, DO_REM, corners[3], '1), 64'd0, 1, "REM overflow");
        run_timed(make_req(1'b1, DO_DIVW, a, wz), '1, 1, "DIVW by zero");
        run_timed(make_req(1'b1, DO_DIVUW, a, wz), '1, 1, "DIVUW by zero");
        run_timed(make_req(1'b1, DO_REMW, a, wz), 64'hffff_ffff_89ab_cdef, 1, "REMW by zero");
        run_timed(make_req(1'b1, DO_REMUW, a, wz), 64'hffff_ffff_89ab_cdef, 1, "REMUW by zero");
        run_timed(make_req(1'b1, DO_DIVW, wmin, wm1), 64'hffff_ffff_8000_0000, 1, "DIVW overflow");
        run_timed(make_req(1'b1, DO_REMW, wmin, wm1), 64'd0, 1, "REMW overflow");
        report_test("divide special cases", e0);
    endtask

    // keeps req_valid high with the next request while the previous one is in flight
    task automatic test_mixed();
        md_req_t reqs [8];
        logic [63:0] exp_q [$];
        logic [63:0] a;
        logic [63:0] b;
        logic fire;
        int e0;
        int idx;
        int got_n;
        int pending;
        int guard;
        e0 = n_errors;
        for (int k = 0; k < 8; k++) begin
            a = rand64();
            b = rand64() >> ($urandom % 64);
            if (k % 2 == 0) begin
                reqs[k] = make_req(1'b0, 3'($urandom % 5), a, b);
                exp_q.push_back(model_mul(reqs[k].op.mul, a, b));
            end else begin
                reqs[k] = make_req(1'b1, 3'($urandom % 8), a, b);
                exp_q.push_back(model_div(reqs[k].op.div, a, b));
            end
        end
        idx = 0;
        got_n = 0;
        pending = 0;
        guard = 0;
        req = reqs[0];
        req_valid = 1'b1;
        while (got_n < 8 && guard < 8 * 80) begin
            // both high now means the coming rising edge accepts
            fire = req_valid && req_ready;
            @(posedge clk);
            @(negedge clk);
            guard++;
            if (fire) begin
                pending++;
                idx++;
                if (idx < 8) begin
                    req = reqs[idx];
                end else begin
                    req_valid = 1'b0;
                end
            end
            if (resp_valid) begin
                check_eq(64'(pending), 64'd1, "one request in flight at a mixed response");
                check_eq(resp.result, exp_q.pop_front(), $sformatf("mixed response %0d", got_n));
                pending--;
                got_n++;
            end
            check_eq(64'(req_ready), 64'(pending == 0), "req_ready during mixed traffic");
        end
        req_valid = 1'b0;
        if (got_n < 8) begin
            $display("error at %0t: mixed traffic got only %0d of 8 responses", $time, got_n);
            n_errors++;
        end
        report_test("mixed traffic", e0);
    endtask

    initial begin
        void'($urandom(SEED));
        n_checks = 0;
        n_errors = 0;
        n_tests = 0;
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset();
        test_results(1'b0);
        test_mul_latency();
        test_results(1'b1);
        test_div_special();
        test_mixed();
        n_errors += dut.u_asserts.fail_count;
        $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- risu64_muldiv.f
design/risu64_pkg.sv
design/mul.sv
design/div.sv
design/muldiv_unit.sv
dv/muldiv_asserts.sv
dv/tb_top.sv
